/* list.f */
verilog/fetch_pkg.sv
verilog/fetch_mem_if.sv
verilog/fetch_controller.sv
verilog/fetch_reg.sv
verilog/icache.sv
verilog/fetch.sv
verification/axi_mem_model.sv
verification/fetch_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vfetch_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1

/* verification/fetch_tb.sv */
module fetch_tb
  import fetch_pkg::*;
();

  localparam logic [XLEN-1:0]   PATTERN = 32'hA5A5_0000;
  localparam int unsigned       SEED    = 32'h465d_7838;
  localparam int                TIMEOUT = 200;   // Falling edges per wait
  localparam logic [ADDR_W-1:0] JUNK_PC = 32'h8000_0F00;
  localparam logic [ADDR_W-1:0] LINE_A  = 32'h8000_0080;
  localparam logic [ADDR_W-1:0] LINE_B  = 32'h8000_0180;   // Same index as LINE_A

  logic              clock;
  logic              reset;
  logic              flush_i;
  logic              valid_post_o;
  logic              ready_post_i;
  logic              branch_en_i;
  logic [ADDR_W-1:0] dnpc_i;
  logic [ADDR_W-1:0] pc_o;
  logic [XLEN-1:0]   inst_o;
  logic              arready_i;
  logic              arvalid_o;
  logic [ADDR_W-1:0] araddr_o;
  logic              rready_o;
  logic              rvalid_i;
  logic [XLEN-1:0]   rdata_i;
  logic              rlast_i;
  int                ar_count;

  int                errors = 0;
  int                checks = 0;
  logic [ADDR_W-1:0] exp_pc;
  int                gap;           // Falling edges since the last hand-off
  logic              keep_ready;    // ready_post_i level between hand-offs
  logic              idle_branch;
  event              abort_run;

  always #4 clock = ~clock;

  fetch u_dut (.*);

  axi_mem_model slave (
    .clock(clock), .reset(reset),
    .arvalid_i(arvalid_o), .arready_o(arready_i), .araddr_i(araddr_o),
    .rvalid_o(rvalid_i), .rready_i(rready_o), .rdata_o(rdata_i), .rlast_o(rlast_i),
    .ar_count_o(ar_count)
  );

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("** Error %s: %s expected %h, actual %h", test, what, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  // Ends the run from its own process after a timeout
  initial begin
    @(abort_run);
    finish_run();
  end

  task automatic timed_out(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
    -> abort_run;
    forever @(negedge clock);   // Parked until the run ends
  endtask

  task automatic check_bursts(input string test, input int since, input int expected);
    check_value(test, "AR requests", 32'(expected), 32'(ar_count - since));
  endtask

  // Outputs while reset is held
  task automatic check_reset();
    check_value("reset", "valid_post_o", 32'd0, 32'(valid_post_o));
    check_value("reset", "arvalid_o", 32'd0, 32'(arvalid_o));
    check_value("reset", "rready_o", 32'd0, 32'(rready_o));
    check_value("reset", "pc_o", RESET_PC, pc_o);
  endtask

  // Wait for the offered instruction and compare it with the expected PC
  task automatic wait_instr(input string test);
    int n;
    n = 0;
    while (!valid_post_o && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    gap += n;
    if (!valid_post_o) begin
      timed_out("valid_post_o");
    end else begin
      check_value(test, "pc_o", exp_pc, pc_o);
      check_value(test, "inst_o", exp_pc ^ PATTERN, inst_o);
    end
  endtask

  // Decode not ready, offer must not move
  task automatic hold_instr(input string test, input int cycles);
    int since;
    since = ar_count;
    repeat (cycles) begin
      @(negedge clock);
      check_value(test, "valid_post_o", 32'd1, 32'(valid_post_o));
      check_value(test, "pc_o held", exp_pc, pc_o);
      check_value(test, "inst_o held", exp_pc ^ PATTERN, inst_o);
      check_bursts(test, since, 0);
    end
  endtask

  task automatic take_instr(input logic branch, input logic [ADDR_W-1:0] target);
    ready_post_i = 1'b1;
    branch_en_i  = branch;
    dnpc_i       = branch ? target : JUNK_PC;
    exp_pc       = branch ? target : exp_pc + 32'd4;
    @(negedge clock);
    ready_post_i = keep_ready;
    branch_en_i  = idle_branch;
    dnpc_i       = JUNK_PC;
    gap          = 1;
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(negedge clock);
    flush_i = 1'b0;
  endtask

  task automatic flush_on_refill();
    int n;
    n = 0;
    while (!arvalid_o && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (!arvalid_o) begin
      timed_out("arvalid_o");
    end else begin
      check_value("flush refill", "araddr_o", exp_pc & 32'hFFFF_FFF0, araddr_o);
      pulse_flush();
    end
  endtask

  task automatic test_sequential();
    int since;
    since = ar_count;
    keep_ready   = 1'b1;
    ready_post_i = 1'b1;
    for (int i = 0; i < 8; i++) begin
      wait_instr("sequential");
      if (i == 7) begin
        check_bursts("sequential", since, 2);   // Two lines touched
        keep_ready = 1'b0;
      end
      take_instr(1'b0, '0);
    end
  endtask

  task automatic test_branch();
    int since;
    since = ar_count;
    idle_branch = 1'b1;   // Branch request with nothing on offer
    branch_en_i = 1'b1;
    wait_instr("branch");
    take_instr(1'b0, '0);
    wait_instr("branch");
    take_instr(1'b1, RESET_PC + 32'h40);
    wait_instr("branch");
    take_instr(1'b0, '0);
    wait_instr("branch");
    check_bursts("branch", since, 2);
    idle_branch = 1'b0;
    take_instr(1'b0, '0);
  endtask

  task automatic test_hits();
    logic [ADDR_W-1:0] targets [3];
    int since;
    targets = '{RESET_PC + 32'h4, RESET_PC + 32'h18, RESET_PC + 32'h4C};
    since = ar_count;
    for (int i = 0; i < 4; i++) begin
      wait_instr("hits");
      check_value("hits", "cycles to valid_post_o", 32'd3, 32'(gap));
      if (i == 3) begin
        check_bursts("hits", since, 0);
        take_instr(1'b0, '0);
      end else begin
        take_instr(1'b1, targets[i]);
      end
    end
  endtask

  task automatic test_backpressure();
    int since;
    int span;
    since = ar_count;
    for (int i = 0; i < 4; i++) begin
      wait_instr("backpressure");
      span = $urandom_range(6, 1);
      hold_instr("backpressure", span);
      if (i == 3) begin
        check_bursts("backpressure", since, 1);
      end
      take_instr(1'b0, '0);
    end
  endtask

  task automatic test_flush();
    int since;
    wait_instr("flush");
    since = ar_count;
    pulse_flush();
    take_instr(1'b1, RESET_PC);   // Line 0 was cached before the flush
    wait_instr("flush");
    take_instr(1'b1, RESET_PC + 32'h4);
    wait_instr("flush");
    check_bursts("flush", since, 1);
    since = ar_count;
    take_instr(1'b1, RESET_PC + 32'h78);
    flush_on_refill();
    wait_instr("flush refill");
    take_instr(1'b1, RESET_PC + 32'h74);
    wait_instr("flush refill");
    check_bursts("flush refill", since, 2);
    take_instr(1'b0, '0);
  endtask

  task automatic test_conflict();
    int since;
    wait_instr("conflict");
    since = ar_count;
    for (int i = 0; i < 4; i++) begin
      take_instr(1'b1, (i % 2 == 0) ? LINE_A : LINE_B);
      wait_instr("conflict");
    end
    check_bursts("conflict", since, 4);
    take_instr(1'b0, '0);
  endtask

  initial begin
    void'($urandom(SEED));
    clock        = 1'b0;
    reset        = 1'b1;
    flush_i      = 1'b0;
    ready_post_i = 1'b0;
    branch_en_i  = 1'b0;
    dnpc_i       = JUNK_PC;
    keep_ready   = 1'b0;
    idle_branch  = 1'b0;
    exp_pc       = RESET_PC;
    gap          = 0;
    repeat (10) @(negedge clock);
    check_reset();
    reset = 1'b0;
    test_sequential();
    test_branch();
    test_hits();
    test_backpressure();
    test_flush();
    test_conflict();
    finish_run();
  end

endmodule

/* verification/axi_mem_model.sv */
module axi_mem_model
  import fetch_pkg::*;
(
  input  logic              clock,
  input  logic              reset,

  input  logic              arvalid_i,
  output logic              arready_o,
  input  logic [ADDR_W-1:0] araddr_i,

  output logic              rvalid_o,
  input  logic              rready_i,
  output logic [XLEN-1:0]   rdata_o,
  output logic              rlast_o,

  output int                ar_count_o
);

  function automatic logic [XLEN-1:0] word_at(input logic [ADDR_W-1:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  // One incrementing burst of LINE_WORDS beats
  task automatic serve_burst();
    logic [ADDR_W-1:0] base;
    int unsigned delay;
    logic taken;
    int polls;
    delay = $urandom_range(3);
    repeat (delay) @(negedge clock);   // arvalid holds meanwhile
    base = araddr_i;
    arready_o = 1'b1;
    @(negedge clock);
    arready_o = 1'b0;
    ar_count_o++;
    for (int beat = 0; beat < LINE_WORDS; beat++) begin
      delay = $urandom_range(2);
      repeat (delay) @(negedge clock);
      rvalid_o = 1'b1;
      rdata_o  = word_at(base + ADDR_W'(4 * beat));
      rlast_o  = (beat == LINE_WORDS - 1);
      polls = 0;
      do begin
        taken = rready_i;   // Stable here, so it predicts the next edge
        @(negedge clock);
        polls++;
      end while (!taken && polls < 64);
      if (!taken) begin
        $display("Timeout while waiting for rready_o");
      end
      rvalid_o = 1'b0;
      rlast_o  = 1'b0;
    end
  endtask

  initial begin
    arready_o  = 1'b0;
    rvalid_o   = 1'b0;
    rdata_o    = '0;
    rlast_o    = 1'b0;
    ar_count_o = 0;
    forever begin
      @(negedge clock);
      if (!reset && arvalid_i) begin
        serve_burst();
      end
    end
  end

endmodule

/* verilog/fetch.sv */
module fetch
  import fetch_pkg::*;
(
  input  logic              clock,
  input  logic              reset,

  input  logic              flush_i,

  // Decode handshake
  output logic              valid_post_o,
  input  logic              ready_post_i,

  input  logic              branch_en_i,
  input  logic [ADDR_W-1:0] dnpc_i,

  output logic [ADDR_W-1:0] pc_o,
  output logic [XLEN-1:0]   inst_o,

  // AR: read address channel
  input  logic              arready_i,
  output logic              arvalid_o,
  output logic [ADDR_W-1:0] araddr_o,

  // R: read data channel
  output logic              rready_o,
  input  logic              rvalid_i,
  input  logic [XLEN-1:0]   rdata_i,
  input  logic              rlast_i
);

  logic pc_we;
  logic inst_we;

  fetch_mem_if mem_if ();

  fetch_controller controller (
    .clock        (clock),
    .reset        (reset),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .pc_we_o      (pc_we),
    .inst_we_o    (inst_we),
    .mem          (mem_if)
  );

  fetch_reg reg0 (
    .clock        (clock),
    .reset        (reset),
    .pc_we_i      (pc_we),
    .inst_we_i    (inst_we),
    .branch_en_i  (branch_en_i),
    .dnpc_i       (dnpc_i),
    .pc_o         (pc_o),
    .inst_o       (inst_o),
    .mem          (mem_if)
  );

  // Cache owns the external read port
  icache icache0 (
    .clock        (clock),
    .reset        (reset),
    .flush_i      (flush_i),
    .mem          (mem_if),
    .arready_i    (arready_i),
    .arvalid_o    (arvalid_o),
    .araddr_o     (araddr_o),
    .rready_o     (rready_o),
    .rvalid_i     (rvalid_i),
    .rlast_i      (rlast_i),
    .rdata_i      (rdata_i)
  );

endmodule

/* verilog/icache.sv */
module icache
  import fetch_pkg::*;
(
  input  logic              clock,
  input  logic              reset,

  input  logic              flush_i,

  fetch_mem_if.cache        mem,

  // AXI4 read address channel
  input  logic              arready_i,
  output logic              arvalid_o,
  output logic [ADDR_W-1:0] araddr_o,

  // AXI4 read data channel
  output logic              rready_o,
  input  logic              rvalid_i,
  input  logic              rlast_i,
  input  logic [XLEN-1:0]   rdata_i
);

  cache_state_t state_q;
  cache_state_t state_d;

  // Line storage
  logic [TAG_W-1:0]        tag_q   [ICACHE_LINES];
  logic [XLEN-1:0]         data_q  [ICACHE_LINES][LINE_WORDS];
  logic [ICACHE_LINES-1:0] valid_q;

  // Latched request
  logic [TAG_W-1:0]      req_tag_q;
  logic [INDEX_W-1:0]    req_idx_q;
  logic [WORD_OFF_W-1:0] req_off_q;

  logic [WORD_OFF_W-1:0] beat_q;
  logic                  flush_pend_q;   // Flush seen during refill

  logic req_fire;
  logic hit;
  logic beat_fire;
  logic last_beat;

  assign req_fire  = mem.arvalid && mem.arready;
  assign hit       = valid_q[req_idx_q] && (tag_q[req_idx_q] == req_tag_q);
  assign beat_fire = rvalid_i && rready_o;
  assign last_beat = beat_fire && rlast_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CS_IDLE: begin
        if (mem.arvalid) begin
          state_d = CS_LOOKUP;
        end
      end
      CS_LOOKUP: begin
        if (!hit) begin
          state_d = CS_AR;
        end else if (!mem.rready) begin
          state_d = CS_RESP;   // Hold the hit word
        end else begin
          state_d = CS_IDLE;
        end
      end
      CS_AR: begin
        if (arready_i) begin
          state_d = CS_R;
        end
      end
      CS_R: begin
        if (last_beat) begin
          state_d = CS_RESP;
        end
      end
      CS_RESP: begin
        if (mem.rready) begin
          state_d = CS_IDLE;
        end
      end
      default: begin
        state_d = CS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= CS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clock) begin
    if (req_fire) begin
      req_tag_q <= mem.araddr[ADDR_W-1 -: TAG_W];
      req_idx_q <= mem.araddr[IDX_LSB +: INDEX_W];
      req_off_q <= mem.araddr[OFF_LSB +: WORD_OFF_W];
    end
  end

  // Beat counter walks the line in address order
  always_ff @(posedge clock) begin
    if (reset) begin
      beat_q <= '0;
    end else if (state_q == CS_AR) begin
      beat_q <= '0;
    end else if (beat_fire) begin
      beat_q <= beat_q + WORD_OFF_W'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (beat_fire) begin
      data_q[req_idx_q][beat_q] <= rdata_i;
    end
    if (last_beat) begin
      tag_q[req_idx_q] <= req_tag_q;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      flush_pend_q <= 1'b0;
    end else if (req_fire) begin
      flush_pend_q <= 1'b0;
    end else if (flush_i) begin
      flush_pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= '0;
      end
      // A flush during the refill leaves the line invalid
      if (last_beat && !flush_pend_q && !flush_i) begin
        valid_q[req_idx_q] <= 1'b1;
      end
    end
  end

  // Internal word return
  assign mem.arready = (state_q == CS_IDLE);
  assign mem.rvalid  = (state_q == CS_RESP) || ((state_q == CS_LOOKUP) && hit);
  assign mem.rdata   = data_q[req_idx_q][req_off_q];

  // Refill burst, line aligned
  assign arvalid_o = (state_q == CS_AR);
  assign araddr_o  = {req_tag_q, req_idx_q, {(WORD_OFF_W + BYTE_OFF_W){1'b0}}};
  assign rready_o  = (state_q == CS_R);

endmodule

/* verilog/fetch_reg.sv */
module fetch_reg
  import fetch_pkg::*;
(
  input  logic              clock,
  input  logic              reset,

  input  logic              pc_we_i,
  input  logic              inst_we_i,

  input  logic              branch_en_i,
  input  logic [ADDR_W-1:0] dnpc_i,

  output logic [ADDR_W-1:0] pc_o,
  output logic [XLEN-1:0]   inst_o,

  fetch_mem_if.regs         mem
);

  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_next;
  logic [XLEN-1:0]   inst_q;

  // Branch target wins over sequential PC
  assign pc_next = branch_en_i ? dnpc_i : pc_q + ADDR_W'(4);

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= RESET_PC;
    end else if (pc_we_i) begin
      pc_q <= pc_next;
    end
  end

  always_ff @(posedge clock) begin
    if (inst_we_i) begin
      inst_q <= mem.rdata;
    end
  end

  assign mem.araddr = pc_q;   // Fetch address straight from PC
  assign pc_o       = pc_q;
  assign inst_o     = inst_q;

endmodule

/* verilog/fetch_controller.sv */
module fetch_controller
  import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  output logic       valid_post_o,
  input  logic       ready_post_i,

  output logic       pc_we_o,
  output logic       inst_we_o,

  fetch_mem_if.ctrl  mem
);

  fetch_state_t state_q;
  fetch_state_t state_d;

  logic req_fire;
  logic word_fire;
  logic post_fire;

  assign req_fire  = mem.arvalid && mem.arready;
  assign word_fire = mem.rvalid && mem.rready;
  assign post_fire = valid_post_o && ready_post_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FS_START: begin
        state_d = FS_REQ;
      end
      FS_REQ: begin
        if (req_fire) begin
          state_d = FS_WAIT;
        end
      end
      FS_WAIT: begin
        if (word_fire) begin
          state_d = FS_VALID;
        end
      end
      FS_VALID: begin
        if (post_fire) begin
          state_d = FS_REQ;   // Next fetch from updated PC
        end
      end
      default: begin
        state_d = FS_START;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= FS_START;
    end else begin
      state_q <= state_d;
    end
  end

  assign mem.arvalid  = (state_q == FS_REQ);
  assign mem.rready   = (state_q == FS_WAIT);
  assign valid_post_o = (state_q == FS_VALID);

  // Register strobes
  assign inst_we_o = word_fire;
  assign pc_we_o   = post_fire;

endmodule

/* verilog/fetch_mem_if.sv */
interface fetch_mem_if
  import fetch_pkg::*;
();

  // Request side
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;

  // Word return side
  logic              rvalid;
  logic              rready;
  logic [XLEN-1:0]   rdata;

  modport ctrl (
    output arvalid,
    output rready,
    input  arready,
    input  rvalid
  );

  modport regs (
    output araddr,
    input  rdata
  );

  modport cache (
    input  arvalid,
    input  rready,
    input  araddr,
    output arready,
    output rvalid,
    output rdata
  );

endinterface

/* verilog/fetch_pkg.sv */
package fetch_pkg;

  // Datapath widths
  localparam int XLEN   = 32;
  localparam int ADDR_W = 32;

  localparam logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000;

  // Instruction cache geometry
  localparam int LINE_WORDS   = 4;   // Also the refill burst length
  localparam int ICACHE_LINES = 16;
  localparam int INDEX_W      = 4;
  localparam int WORD_OFF_W   = 2;
  localparam int BYTE_OFF_W   = 2;
  localparam int TAG_W        = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

  // Address field positions
  localparam int OFF_LSB = BYTE_OFF_W;
  localparam int IDX_LSB = BYTE_OFF_W + WORD_OFF_W;

  // Fetch controller states
  typedef enum logic [1:0] {
    FS_START,   // First cycle out of reset
    FS_REQ,
    FS_WAIT,
    FS_VALID
  } fetch_state_t;

  // Cache states
  typedef enum logic [2:0] {
    CS_IDLE,
    CS_LOOKUP,
    CS_AR,      // Refill address phase
    CS_R,       // Refill beats
    CS_RESP
  } cache_state_t;

endpackage
